// ==== logic/core_pkg.sv ====
package core_pkg;

	// One data word or byte address
	typedef logic [31:0] word;

	// Byte address without its two low bits
	typedef logic [29:0] ptr;

	typedef logic [3:0] reg_num;

	// Bit i set means register i takes part in the transfer
	typedef logic [15:0] reg_list;

	// Sequencer states of a block transfer
	typedef enum logic [1:0] {
		ISSUE,
		TRANSFER,
		BASE_WRITEBACK
	} ctrl_cycle;

endpackage

// ==== logic/core_control_cycles.sv ====
`timescale 1ns/10ps

module core_control_cycles (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue,
	input  logic                empty,
	input  logic                last,
	input  logic                mem_ready,
	input  logic                wb_pending,
	output core_pkg::ctrl_cycle cycle,
	output core_pkg::ctrl_cycle next_cycle
);

	import core_pkg::*;

	always_comb begin
		next_cycle = cycle;

		case (cycle)
			ISSUE: begin
				// Empty list still spends one stall cycle, with nothing written
				if (issue)
					next_cycle = empty ? BASE_WRITEBACK : TRANSFER;
			end

			TRANSFER: begin
				if (mem_ready && last)
					next_cycle = wb_pending ? BASE_WRITEBACK : ISSUE;
			end

			BASE_WRITEBACK:
				next_cycle = ISSUE;

			default:
				next_cycle = ISSUE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			cycle <= ISSUE;
		else
			cycle <= next_cycle;
	end

	// Memory answers only while a transfer waits for it
	assert property (@(posedge clk) disable iff (reset) cycle != TRANSFER |-> !mem_ready);

endmodule

// ==== logic/core_control_ldst_pop.sv ====
`timescale 1ns/10ps

module core_control_ldst_pop (
	input  core_pkg::reg_list regs,
	output logic              valid,
	output core_pkg::reg_num  pop_lower,
	output core_pkg::reg_num  pop_upper,
	output core_pkg::reg_list next_lower,
	output core_pkg::reg_list next_upper
);

	import core_pkg::*;

	assign valid = |regs;

	// Scan downwards so the lowest set bit is the last one kept
	always_comb begin
		pop_lower = '0;
		for (int i = 15; i >= 0; i--) begin
			if (regs[i])
				pop_lower = reg_num'(i);
		end
	end

	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < 16; i++) begin
			if (regs[i])
				pop_upper = reg_num'(i);
		end
	end

	// Remaining lists after each pop
	assign next_lower = regs & ~(reg_list'(1) << pop_lower);
	assign next_upper = regs & ~(reg_list'(1) << pop_upper);

endmodule

// ==== logic/core_control.sv ====
`timescale 1ns/10ps

module core_control (
	input  logic              clk,
	input  logic              reset,
	input  logic              issue,
	input  logic              load,
	input  logic              pre_indexed,
	input  logic              increment,
	input  logic              writeback,
	input  core_pkg::reg_num  rn,
	input  core_pkg::reg_list regs,
	input  core_pkg::word     rd_value_a,
	input  core_pkg::word     rd_value_b,
	input  core_pkg::word     mem_data_rd,
	input  logic              mem_ready,
	output logic              stall,
	output core_pkg::reg_num  ra,
	output core_pkg::reg_num  rb,
	output core_pkg::reg_num  wr_reg,
	output logic              wr_en,
	output core_pkg::word     wr_value,
	output core_pkg::word     mem_data_wr,
	output core_pkg::ptr      mem_addr,
	output logic              mem_start,
	output logic              mem_write
);

	import core_pkg::*;

	ctrl_cycle cycle, next_cycle;

	logic       ldst_increment, step_increment, wb_pending;
	logic       pop_valid, advance, pending;
	logic [4:0] reg_count;
	reg_num     base_reg, cur_reg, pop_lower, pop_upper, popped;
	reg_list    mem_regs, pop_regs, next_lower, next_upper, next_regs;
	word        first_addr, offset, wb_base, new_base;

	core_control_cycles ctrl_cycles (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.empty(!pop_valid),
		.last(mem_regs == '0),
		.mem_ready(mem_ready),
		.wb_pending(wb_pending),
		.cycle(cycle),
		.next_cycle(next_cycle)
	);

	core_control_ldst_pop ctrl_ldst_pop (
		.regs(pop_regs),
		.valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_lower),
		.next_upper(next_upper)
	);

	// Decode fields are live only in the issue cycle
	assign step_increment = cycle == ISSUE ? increment : ldst_increment;
	assign pop_regs = cycle == ISSUE ? regs : mem_regs;
	assign popped = step_increment ? pop_lower : pop_upper;
	assign next_regs = step_increment ? next_lower : next_upper;

	assign stall = cycle != ISSUE;
	assign ra = cycle == ISSUE ? rn : base_reg;
	assign rb = cur_reg; // Store source for the access in flight
	assign mem_data_wr = rd_value_b;

	assign wr_reg = cycle == BASE_WRITEBACK ? base_reg : cur_reg;
	assign wr_value = cycle == BASE_WRITEBACK ? new_base : mem_data_rd;
	assign wr_en = (cycle == TRANSFER && mem_ready && !mem_write)
	             || (cycle == BASE_WRITEBACK && wb_pending);

	// Entering TRANSFER or moving on to the next register
	assign advance = next_cycle == TRANSFER && (cycle != TRANSFER || mem_ready);

	always_comb begin
		reg_count = '0;
		for (int i = 0; i < 16; i++)
			reg_count = reg_count + 5'(regs[i]);
	end

	assign offset = word'({reg_count, 2'b00});
	assign wb_base = increment ? rd_value_a + offset : rd_value_a - offset;

	// Decrement walks down from the top, so only writeback needs n
	always_comb begin
		first_addr = rd_value_a;
		if (pre_indexed)
			first_addr = increment ? rd_value_a + 32'd4 : rd_value_a - 32'd4;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_start <= 1'b0;
			mem_write <= 1'b0;
			wb_pending <= 1'b0;
			mem_regs <= '0;
			pending <= 1'b0;
		end else begin
			mem_start <= advance;
			pending <= mem_start || (pending && !mem_ready);

			if (advance)
				mem_regs <= next_regs;

			if (cycle == ISSUE && issue) begin
				wb_pending <= writeback && pop_valid;
				mem_write <= !load && pop_valid;
			end else if (next_cycle == ISSUE) begin
				mem_write <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cycle == ISSUE && issue) begin
			base_reg <= rn;
			ldst_increment <= increment;
			new_base <= wb_base;
		end

		if (advance) begin
			cur_reg <= popped;
			if (cycle == ISSUE)
				mem_addr <= first_addr[31:2];
			else
				mem_addr <= ldst_increment ? mem_addr + 30'd1 : mem_addr - 30'd1;
		end
	end

	// Issue only between instructions
	assert property (@(posedge clk) disable iff (reset) stall |-> !issue);

	// One access in flight at a time
	assert property (@(posedge clk) disable iff (reset) mem_start |-> !pending);

endmodule

// ==== logic/core_regfile.sv ====
`timescale 1ns/10ps

module core_regfile (
	input  logic             clk,
	input  logic             reset,
	input  core_pkg::reg_num ra,
	input  core_pkg::reg_num rb,
	input  core_pkg::reg_num wr_reg,
	input  logic             wr_en,
	input  core_pkg::word    wr_value,
	output core_pkg::word    rd_value_a,
	output core_pkg::word    rd_value_b
);

	import core_pkg::*;

	word regs [16];

	// Asynchronous reads
	assign rd_value_a = regs[ra];
	assign rd_value_b = regs[rb];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_reg] <= wr_value;
		end
	end

endmodule

// ==== logic/core_ldst_top.sv ====
`timescale 1ns/10ps

module core_ldst_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              issue,
	input  logic              load,
	input  logic              pre_indexed,
	input  logic              increment,
	input  logic              writeback,
	input  core_pkg::reg_num  rn,
	input  core_pkg::reg_list regs,
	input  logic              mem_ready,
	input  core_pkg::word     mem_data_rd,
	output logic              stall,
	output core_pkg::ptr      mem_addr,
	output logic              mem_start,
	output logic              mem_write,
	output core_pkg::word     mem_data_wr
);

	import core_pkg::*;

	reg_num ra, rb, wr_reg;
	logic   wr_en;
	word    wr_value, rd_value_a, rd_value_b;

	core_control control0 (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.load(load),
		.pre_indexed(pre_indexed),
		.increment(increment),
		.writeback(writeback),
		.rn(rn),
		.regs(regs),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.mem_data_rd(mem_data_rd),
		.mem_ready(mem_ready),
		.stall(stall),
		.ra(ra),
		.rb(rb),
		.wr_reg(wr_reg),
		.wr_en(wr_en),
		.wr_value(wr_value),
		.mem_data_wr(mem_data_wr),
		.mem_addr(mem_addr),
		.mem_start(mem_start),
		.mem_write(mem_write)
	);

	core_regfile regfile0 (
		.clk(clk),
		.reset(reset),
		.ra(ra),
		.rb(rb),
		.wr_reg(wr_reg),
		.wr_en(wr_en),
		.wr_value(wr_value),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b)
	);

endmodule

// ==== verif/core_ldst_tb.sv ====
`timescale 1ns/10ps

module core_ldst_tb;

	import core_pkg::*;

	localparam int clk_period = 4;
	localparam int num_tests = 6;
	localparam int instr_per_test = 8;
	localparam int max_instr_cycles = 90; // 16 transfers of up to 5 cycles, plus issue and writeback

	logic    clk, reset, issue, load, pre_indexed, increment, writeback;
	reg_num  rn;
	reg_list regs;
	logic    mem_ready, stall, mem_start, mem_write;
	word     mem_data_rd, mem_data_wr;
	ptr      mem_addr;

	word         mem [1024];
	word         exp_regs [16]; // Register file as the addressing rules predict it
	ptr          acc_addr [$];
	logic        acc_write [$];
	word         acc_data [$];
	logic [15:0] lfsr_state;
	int          stall_cycles;
	int          test_errors, tests_passed, tests_failed;

	core_ldst_top dut0 (.*);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic lfsr_step();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic word rand_bits(input int count);
		word value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], lfsr_step()};
		return value;
	endfunction

	task automatic compare_word(input string name, input word expected, input word actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_ptr(input string name, input ptr expected, input ptr actual);
		if (actual !== expected) begin
			$display("Error %s: expected address %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error %s: expected level %b, actual %b", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic fill_memory(input int first, input int count);
		for (int i = 0; i < count; i++)
			mem[10'(first + i)] = rand_bits(32);
	endtask

	// Answers one access after 1 to 4 cycles
	task automatic serve_access();
		ptr addr;
		int delay;
		addr = mem_addr;
		acc_addr.push_back(mem_addr);
		acc_write.push_back(mem_write);
		acc_data.push_back(mem_data_wr);
		if (mem_write)
			mem[addr[9:0]] = mem_data_wr;
		delay = 1 + int'(rand_bits(2));
		for (int i = 0; i < delay; i++) begin
			@(posedge clk);
			#1;
			if (mem_start === 1'b1) begin
				$display("A memory access started before the previous one was answered");
				test_errors++;
			end
			if (i == delay - 1) begin
				mem_ready = 1'b1;
				mem_data_rd = mem[addr[9:0]];
			end
		end
		@(posedge clk);
		#1;
		mem_ready = 1'b0;
		mem_data_rd = '0;
	endtask

	initial begin
		mem_ready = 1'b0;
		mem_data_rd = '0;
		forever begin
			@(posedge clk);
			#1;
			while (mem_start === 1'b1)
				serve_access();
		end
	end

	task automatic block_transfer(input logic ld, input logic pre, input logic inc,
			input logic wb, input reg_num base_reg, input reg_list list);
		int cycles;
		acc_addr.delete();
		acc_write.delete();
		acc_data.delete();
		load = ld;
		pre_indexed = pre;
		increment = inc;
		writeback = wb;
		rn = base_reg;
		regs = list;
		issue = 1'b1;
		@(posedge clk);
		#1;
		issue = 1'b0;
		cycles = 0;
		while (stall === 1'b1 && cycles <= max_instr_cycles) begin
			cycles++;
			@(posedge clk);
			#1;
		end
		if (cycles > max_instr_cycles) begin
			$display("Instruction did not retire, stall stayed high for %0d cycles", cycles);
			test_errors++;
		end
		stall_cycles = cycles;
	endtask

	// Lowest register sits at the lowest address whichever end the mode starts from
	task automatic check_transfer(input string name, input logic ld, input logic pre,
			input logic inc, input logic wb, input reg_num base_reg, input reg_list list,
			input word base);
		int     n;
		int     pos;
		word    lowest;
		word    addr;
		reg_num asc [$];
		n = $countones(list);
		for (int i = 0; i < 16; i++)
			if (list[i])
				asc.push_back(reg_num'(i));
		if (inc)
			lowest = pre ? base + 32'd4 : base;
		else
			lowest = pre ? base - word'(4 * n) : base - word'(4 * n) + 32'd4;
		if (acc_addr.size() != n) begin
			$display("Error %s: expected %0d memory accesses, actual %0d", name, n,
				acc_addr.size());
			test_errors++;
		end
		for (int j = 0; j < n && j < acc_addr.size(); j++) begin
			pos = inc ? j : n - 1 - j;
			addr = lowest + word'(4 * pos);
			compare_ptr(name, addr[31:2], acc_addr[j]);
			compare_level(name, !ld, acc_write[j]);
			if (ld)
				exp_regs[asc[pos]] = mem[addr[11:2]];
			else
				compare_word(name, exp_regs[asc[pos]], acc_data[j]);
		end
		if (wb && n > 0)
			exp_regs[base_reg] = inc ? base + word'(4 * n) : base - word'(4 * n);
	endtask

	task automatic do_ldm(input string name, input logic pre, input logic inc, input logic wb,
			input reg_num base_reg, input reg_list list);
		word base;
		base = exp_regs[base_reg];
		block_transfer(1'b1, pre, inc, wb, base_reg, list);
		check_transfer(name, 1'b1, pre, inc, wb, base_reg, list, base);
	endtask

	task automatic do_stm(input string name, input logic pre, input logic inc, input logic wb,
			input reg_num base_reg, input reg_list list);
		word base;
		base = exp_regs[base_reg];
		block_transfer(1'b0, pre, inc, wb, base_reg, list);
		check_transfer(name, 1'b0, pre, inc, wb, base_reg, list, base);
	endtask

	task automatic check_single_stall(input string name);
		if (stall_cycles != 1) begin
			$display("Error %s: expected 1 stall cycle, actual %0d", name, stall_cycles);
			test_errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		issue = 1'b0;
		load = 1'b0;
		pre_indexed = 1'b0;
		increment = 1'b0;
		writeback = 1'b0;
		rn = '0;
		regs = '0;
		lfsr_state = 16'd9345;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < 16; i++)
			exp_regs[i] = '0;
		for (int i = 0; i < 1024; i++)
			mem[i] = word'(i) * 32'h0100_0193 ^ 32'h5A5A_0000;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		compare_level("reset", 1'b0, stall);
		compare_level("reset", 1'b0, mem_start);
		compare_level("reset", 1'b0, mem_write);
		do_stm("reset", 1'b0, 1'b1, 1'b0, 4'd0, 16'hFFFF);
		finish_test("reset");

		fill_memory(0, 16);
		mem[3] = 32'h0000_0400; // Base values for r4, r8 and r12
		mem[7] = 32'h0000_0800;
		mem[11] = 32'h0000_0C00;
		do_ldm("round_trip", 1'b0, 1'b1, 1'b0, 4'd0, 16'hFFFE);
		do_stm("round_trip", 1'b0, 1'b1, 1'b0, 4'd4, 16'hFFFE);
		finish_test("round_trip");

		fill_memory('h1F0, 32);
		for (int m = 0; m < 4; m++) begin
			do_ldm("addressing_modes", m[1], m[0], 1'b0, 4'd8, 16'h00A6);
			do_stm("addressing_modes", m[1], m[0], 1'b0, 4'd8, 16'h7A12);
		end
		finish_test("addressing_modes");

		fill_memory('h2F0, 32);
		do_ldm("base_writeback", 1'b0, 1'b1, 1'b1, 4'd12, 16'h000E);
		do_stm("base_writeback", 1'b0, 1'b1, 1'b0, 4'd4, 16'h1000);
		do_ldm("base_writeback", 1'b1, 1'b0, 1'b1, 4'd12, 16'h00C0);
		do_stm("base_writeback", 1'b0, 1'b1, 1'b0, 4'd4, 16'h1000);
		do_ldm("base_writeback", 1'b1, 1'b1, 1'b0, 4'd12, 16'h0006); // Base stays put
		do_stm("base_writeback", 1'b0, 1'b1, 1'b0, 4'd4, 16'h1000);
		do_stm("base_writeback", 1'b0, 1'b0, 1'b1, 4'd12, 16'h000E);
		do_stm("base_writeback", 1'b0, 1'b1, 1'b0, 4'd4, 16'h1000);
		finish_test("base_writeback");

		do_ldm("empty_list", 1'b0, 1'b1, 1'b1, 4'd8, 16'h0000);
		check_single_stall("empty_list");
		do_stm("empty_list", 1'b1, 1'b0, 1'b1, 4'd8, 16'h0000);
		check_single_stall("empty_list");
		do_stm("empty_list", 1'b0, 1'b1, 1'b0, 4'd4, 16'h0100); // r8 still holds its base
		finish_test("empty_list");

		fill_memory('h1E0, 64);
		do_ldm("memory_latency", 1'b0, 1'b0, 1'b0, 4'd8, 16'hFEFF);
		do_stm("memory_latency", 1'b1, 1'b1, 1'b0, 4'd8, 16'hFFFF);
		fill_memory('h1E0, 64);
		do_ldm("memory_latency", 1'b1, 1'b1, 1'b0, 4'd8, 16'hFEFF);
		do_stm("memory_latency", 1'b0, 1'b0, 1'b0, 4'd8, 16'hFFFF);
		fill_memory('h1E0, 64);
		do_ldm("memory_latency", 1'b1, 1'b0, 1'b0, 4'd8, 16'hFEFF);
		do_stm("memory_latency", 1'b0, 1'b1, 1'b0, 4'd8, 16'hFFFF);
		finish_test("memory_latency");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(num_tests * instr_per_test * max_instr_cycles * clk_period + 20 * clk_period);
		$display("Watchdog expired, the tests ran longer than their worst-case length");
		$display("Test failed");
		$finish;
	end

endmodule

// ==== core_ldst.f ====
logic/core_pkg.sv
logic/core_control_cycles.sv
logic/core_control_ldst_pop.sv
logic/core_control.sv
logic/core_regfile.sv
logic/core_ldst_top.sv
verif/core_ldst_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module core_ldst_tb -f core_ldst.f -Mdir obj_dir -o core_ldst_sim

output=$(./obj_dir/core_ldst_sim)
echo "$output"
echo "$output" | grep -qx "Test completed successfully"
